// ==== common/mos8501_pkg.sv ====
package mos8501_pkg;

	////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////

	// The 6502 family drives a 16 bit address bus
	localparam int ADDR_WIDTH = 16;

	// Data moves one byte at a time
	localparam int DATA_WIDTH = 8;

	// Widest on-chip port the shell can hold
	// Smaller ports use only the low bits of port_t
	localparam int PORT_MAX_WIDTH = 8;

	////////////////////////////////////////
	// Typedefs
	////////////////////////////////////////

	// One address word as seen on the system bus
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// One byte on the data bus
	typedef logic [DATA_WIDTH-1:0] data_t;

	// Port pins, direction bits and data bits all share this shape
	typedef logic [PORT_MAX_WIDTH-1:0] port_t;

	////////////////////////////////////////
	// Port register map
	////////////////////////////////////////

	// The direction register sits at the very bottom of the address space
	localparam addr_t PORT_DIR_ADDR = 16'h0000;

	// The data register follows right after it
	localparam addr_t PORT_DATA_ADDR = 16'h0001;

	////////////////////////////////////////
	// Structs
	////////////////////////////////////////

	// One core cycle as the core presents it to the shell
	// The we bit is high when the core writes
	typedef struct packed {
		addr_t address;
		data_t data;
		logic  we;
	} core_bus_t;

	// Decoded port request handed from the decoder to the port block
	// reg_sel low picks the direction register, high picks the data register
	typedef struct packed {
		logic  wr_strobe;
		logic  reg_sel;
		data_t wdata;
	} port_req_t;

endpackage

// ==== src/access_control.sv ====
`timescale 1ns/1ps

module access_control (
	input  mos8501_pkg::core_bus_t core_bus,
	input  mos8501_pkg::data_t     data_in,
	input  mos8501_pkg::data_t     port_rdata,
	input  logic                   enable,
	input  logic                   rdy,
	output mos8501_pkg::port_req_t port_req,
	output mos8501_pkg::data_t     bus_wdata,
	output logic                   core_we,
	output mos8501_pkg::data_t     core_data_in,
	output logic                   core_enable
);

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////

	// Decode is done once here and handed out as strobes
	logic dir_sel;
	logic data_sel;
	logic port_access;
	logic port_write;
	logic port_read;

	// The port occupies the two lowest addresses
	assign dir_sel  = (core_bus.address == mos8501_pkg::PORT_DIR_ADDR);
	assign data_sel = (core_bus.address == mos8501_pkg::PORT_DATA_ADDR);

	// Any access that hits one of the two port registers
	assign port_access = dir_sel | data_sel;

	// Split port accesses by direction
	assign port_write = port_access & core_bus.we;
	assign port_read  = port_access & ~core_bus.we;

	////////////////////////////////////////
	// Port request
	////////////////////////////////////////

	// A register write happens only on a real core step
	// so the strobe also carries enable
	assign port_req.wr_strobe = enable & port_write;

	// Address bit 0 tells the two registers apart
	assign port_req.reg_sel = data_sel;

	// The port takes the byte the core is writing
	assign port_req.wdata = core_bus.data;

	////////////////////////////////////////
	// Bus write data
	////////////////////////////////////////

	// The pass-through of the write direction to the bus side
	assign core_we = core_bus.we;

	// On a port write the real chip leaves the last read byte on the bus
	// That byte is the low address byte, so 0x00 or 0x01
	always_comb
	begin
		if (port_write)
		begin
			if (data_sel)
				bus_wdata = 8'h01;
			else
				bus_wdata = 8'h00;
		end
		else
		begin
			bus_wdata = core_bus.data;
		end
	end

	////////////////////////////////////////
	// Core read data and enable
	////////////////////////////////////////

	// A port read answers from inside the chip, everything else from the bus
	assign core_data_in = port_read ? port_rdata : data_in;

	// rdy low stops the core only when it would read
	// Write cycles always complete, as on the original part
	assign core_enable = (~rdy & ~core_bus.we) ? 1'b0 : enable;

endmodule

// ==== io_port/io_port.sv ====
`timescale 1ns/1ps

module io_port #(
	parameter int PORT_WIDTH = 8
) (
	input  logic                   clk,
	input  logic                   reset,
	input  mos8501_pkg::port_req_t port_req,
	input  mos8501_pkg::port_t     port_in,
	output mos8501_pkg::data_t     port_rdata,
	output mos8501_pkg::port_t     port_out
);

	////////////////////////////////////////
	// Implemented bits
	////////////////////////////////////////

	// Ones in the low PORT_WIDTH positions
	// Bits above the port width read as zero and drive zero
	localparam mos8501_pkg::port_t PORT_MASK =
		mos8501_pkg::port_t'((1 << PORT_WIDTH) - 1);

	// Direction register, a 1 makes the pin an output
	mos8501_pkg::port_t port_dir;

	// Output data register
	mos8501_pkg::port_t port_data;

	// Pin value as the core sees it on a data register read
	mos8501_pkg::port_t port_io;

	////////////////////////////////////////
	// Register writes
	////////////////////////////////////////

	// Both registers clear on reset so every pin starts as an input
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			port_dir  <= '0;
			port_data <= '0;
		end
		else if (port_req.wr_strobe)
		begin
			// reg_sel steers the byte to one of the two registers
			if (port_req.reg_sel)
				port_data <= port_req.wdata & PORT_MASK;
			else
				port_dir <= port_req.wdata & PORT_MASK;
		end
	end

	////////////////////////////////////////
	// Pin mixing
	////////////////////////////////////////

	// Input pins show the outside level
	// output pins show what the core last wrote to them
	always_comb
	begin
		port_io = '0;
		for (int i = 0; i < PORT_WIDTH; i++)
		begin
			if (port_dir[i])
				port_io[i] = port_data[i];
			else
				port_io[i] = port_in[i];
		end
	end

	////////////////////////////////////////
	// Read select and outputs
	////////////////////////////////////////

	// Address 0 returns the direction bits and address 1 the mixed pins
	// The decoder only routes this to the core on a port read
	always_comb
	begin
		if (port_req.reg_sel)
			port_rdata = port_io;
		else
			port_rdata = port_dir;
	end

	// The data register drives the pins directly
	// Its unused bits stay zero because writes are masked
	assign port_out = port_data;

endmodule

// ==== bus/bus_interface.sv ====
`timescale 1ns/1ps

module bus_interface (
	input  logic               clk,
	input  logic               reset,
	input  logic               gate_in,
	input  logic               aec,
	input  mos8501_pkg::addr_t core_address,
	input  logic               core_we,
	input  mos8501_pkg::data_t bus_wdata,
	output mos8501_pkg::addr_t address,
	output mos8501_pkg::data_t data_out,
	output logic               rw
);

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	// Byte captured for the write half of the bus cycle
	mos8501_pkg::data_t data_out_reg;

	// Read/write level as captured in the gate phase
	logic rw_reg;

	// aec one cycle late, so the bus is released a cycle after aec drops
	logic aec_reg;

	////////////////////////////////////////
	// Gate phase capture
	////////////////////////////////////////

	// The data byte is refreshed while gate_in is high
	// and held steady while it is low, when it may appear on the bus
	always_ff @(posedge clk)
	begin
		if (gate_in)
			data_out_reg <= bus_wdata;
	end

	// rw follows the core in the same gate phase
	// Reset puts the bus in read so nothing is driven at start-up
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rw_reg <= 1'b1;
		end
		else if (gate_in)
		begin
			rw_reg <= ~core_we;
		end
	end

	////////////////////////////////////////
	// Bus ownership
	////////////////////////////////////////

	// Track aec with one cycle of delay
	always_ff @(posedge clk)
	begin
		if (reset)
			aec_reg <= 1'b0;
		else
			aec_reg <= aec;
	end

	////////////////////////////////////////
	// Tri-state emulation
	////////////////////////////////////////

	// All ones stands in for a floating bus, so outputs of several
	// masters can be combined with a plain AND outside the shell

	// The address reacts to aec at once, without the delay
	assign address = aec ? core_address : 16'hffff;

	// Without the bus the shell reports a read
	assign rw = aec_reg ? rw_reg : 1'b1;

	// Data is driven only in the second phase of an owned write cycle
	always_comb
	begin
		if (aec_reg && !gate_in && !rw)
			data_out = data_out_reg;
		else
			data_out = 8'hff;
	end

endmodule

// ==== src/mos8501_shell.sv ====
`timescale 1ns/1ps

module mos8501_shell #(
	parameter int PORT_WIDTH = 8
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   enable,
	input  logic                   irq_n,
	input  mos8501_pkg::core_bus_t core_bus,
	input  mos8501_pkg::data_t     data_in,
	input  logic                   gate_in,
	input  logic                   rdy,
	input  logic                   aec,
	input  mos8501_pkg::port_t     port_in,
	output mos8501_pkg::data_t     core_data_in,
	output logic                   core_enable,
	output logic                   core_irq_n,
	output mos8501_pkg::addr_t     address,
	output mos8501_pkg::data_t     data_out,
	output logic                   rw,
	output mos8501_pkg::port_t     port_out
);

	////////////////////////////////////////
	// Internal wiring
	////////////////////////////////////////

	// Decoded request into the port block
	mos8501_pkg::port_req_t port_req;

	// Port read byte back to the decoder
	mos8501_pkg::data_t port_rdata;

	// Byte and direction for the bus side
	mos8501_pkg::data_t bus_wdata;
	logic               core_we;

	// The shell does not touch interrupts
	assign core_irq_n = irq_n;

	// Decode, read data and core enable
	access_control i_access_control (
		.core_bus     (core_bus),
		.data_in      (data_in),
		.port_rdata   (port_rdata),
		.enable       (enable),
		.rdy          (rdy),
		.port_req     (port_req),
		.bus_wdata    (bus_wdata),
		.core_we      (core_we),
		.core_data_in (core_data_in),
		.core_enable  (core_enable)
	);

	// On-chip I/O port at addresses 0 and 1
	io_port #(
		.PORT_WIDTH (PORT_WIDTH)
	) i_io_port (
		.clk        (clk),
		.reset      (reset),
		.port_req   (port_req),
		.port_in    (port_in),
		.port_rdata (port_rdata),
		.port_out   (port_out)
	);

	// System bus side
	bus_interface i_bus_interface (
		.clk          (clk),
		.reset        (reset),
		.gate_in      (gate_in),
		.aec          (aec),
		.core_address (core_bus.address),
		.core_we      (core_we),
		.bus_wdata    (bus_wdata),
		.address      (address),
		.data_out     (data_out),
		.rw           (rw)
	);

endmodule

// ==== tb/mos8501_shell_properties.sv ====
`timescale 1ns/1ps

module mos8501_shell_properties (
	input logic               clk,
	input logic               reset,
	input logic               gate_in,
	input logic               aec,
	input logic               rw,
	input mos8501_pkg::addr_t address,
	input mos8501_pkg::data_t data_out
);

	////////////////////////////////////////
	// Bus ownership
	////////////////////////////////////////

	// Once the bus is given away the shell must report a read
	property rw_high_after_release;
		@(posedge clk) disable iff (reset)
		$fell(aec) |=> rw;
	endproperty

	// The address lines float as soon as aec goes low
	property address_released;
		@(posedge clk) disable iff (reset)
		!aec |-> (address == 16'hffff);
	endproperty

	////////////////////////////////////////
	// Data phase
	////////////////////////////////////////

	// The gate phase belongs to the capture, never to the drive
	property data_idle_in_gate;
		@(posedge clk) disable iff (reset)
		gate_in |-> (data_out == 8'hff);
	endproperty

	assert property (rw_high_after_release)
		else $error("rw is low one cycle after aec fell");

	assert property (address_released)
		else $error("address is driven while aec is low");

	assert property (data_idle_in_gate)
		else $error("data_out is driven while gate_in is high");

endmodule

// Watch the bus side of every shell instance
bind bus_interface mos8501_shell_properties i_properties (
	.clk      (clk),
	.reset    (reset),
	.gate_in  (gate_in),
	.aec      (aec),
	.rw       (rw),
	.address  (address),
	.data_out (data_out)
);

// ==== tb/tb_mos8501_shell.sv ====
`timescale 1ns/1ps

module tb_mos8501_shell;

	////////////////////////////////////////
	// Settings and DUT signals
	////////////////////////////////////////

	// Seven pins as on the real part, so bit 7 exercises the unimplemented bits
	localparam int PORT_WIDTH = 7;
	localparam logic [7:0] PORT_MASK = 8'((1 << PORT_WIDTH) - 1);

	// All tests together take well under 100 cycles
	localparam int TIMEOUT_CYCLES = 400;

	logic clk = 1'b0;
	logic reset;
	logic enable;
	logic irq_n;
	mos8501_pkg::core_bus_t core_bus;
	mos8501_pkg::data_t data_in;
	logic gate_in;
	logic rdy;
	logic aec;
	mos8501_pkg::port_t port_in;
	mos8501_pkg::data_t core_data_in;
	logic core_enable;
	logic core_irq_n;
	mos8501_pkg::addr_t address;
	mos8501_pkg::data_t data_out;
	logic rw;
	mos8501_pkg::port_t port_out;

	// What the port registers should hold after the writes so far
	logic [7:0] dir_model;
	logic [7:0] data_model;

	logic [31:0] rng_state;
	int cycle_count = 0;

	mos8501_shell #(
		.PORT_WIDTH (PORT_WIDTH)
	) i_dut (
		.clk          (clk),
		.reset        (reset),
		.enable       (enable),
		.irq_n        (irq_n),
		.core_bus     (core_bus),
		.data_in      (data_in),
		.gate_in      (gate_in),
		.rdy          (rdy),
		.aec          (aec),
		.port_in      (port_in),
		.core_data_in (core_data_in),
		.core_enable  (core_enable),
		.core_irq_n   (core_irq_n),
		.address      (address),
		.data_out     (data_out),
		.rw           (rw),
		.port_out     (port_out)
	);

	always #20 clk = ~clk;

	// Stop a stuck run instead of letting it spin forever
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function logic [7:0] next_byte();
		rng_state = xorshift32(rng_state);
		return rng_state[7:0];
	endfunction

	// Output pins show the data bit, input pins the outside level
	function automatic logic [7:0] mixed_pins(input logic [7:0] pins);
		return ((data_model & dir_model) | (pins & ~dir_model)) & PORT_MASK;
	endfunction

	task automatic check(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected)
		begin
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Test failed");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	// Present one core cycle from the next rising edge on
	task automatic drive_cycle(input logic [15:0] addr, input logic [7:0] data, input logic we);
		@(posedge clk);
		core_bus.address <= addr;
		core_bus.data    <= data;
		core_bus.we      <= we;
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_reset_state();
		@(negedge clk);
		check("rw", 16'(rw), 16'h0001);
		check("data_out", 16'(data_out), 16'h00ff);
		check("port_out", 16'(port_out), 16'h0000);
		check("address", address, 16'hffff);
		drive_cycle(16'h1234, 8'h00, 1'b0);
		aec   <= 1'b1;
		irq_n <= 1'b0;
		@(negedge clk);
		check("address", address, 16'h1234);
		check("core_irq_n", 16'(core_irq_n), 16'h0000);
		@(posedge clk);
		irq_n <= 1'b1;
		@(negedge clk);
		check("core_irq_n", 16'(core_irq_n), 16'h0001);
	endtask

	task automatic test_port_write_read();
		logic [7:0] dir_val;
		logic [7:0] data_val;
		dir_val  = next_byte();
		data_val = next_byte();
		drive_cycle(16'h0000, dir_val, 1'b1);
		enable <= 1'b1;
		drive_cycle(16'h0001, data_val, 1'b1);
		drive_cycle(16'h0000, 8'h00, 1'b0);
		enable <= 1'b0;
		dir_model  = dir_val & PORT_MASK;
		data_model = data_val & PORT_MASK;
		@(negedge clk);
		check("port_out", 16'(port_out), 16'(data_model));
		check("core_data_in", 16'(core_data_in), 16'(dir_model));
		// Same writes with inverted bytes but no core step
		drive_cycle(16'h0001, ~data_val, 1'b1);
		drive_cycle(16'h0000, ~dir_val, 1'b1);
		drive_cycle(16'h0000, 8'h00, 1'b0);
		@(negedge clk);
		check("port_out", 16'(port_out), 16'(data_model));
		check("core_data_in", 16'(core_data_in), 16'(dir_model));
	endtask

	task automatic test_pin_mixing();
		logic [7:0] pins;
		logic [7:0] bus_byte;
		logic [15:0] addr;
		for (int i = 0; i < 6; i++)
		begin
			pins = next_byte();
			drive_cycle(16'h0001, 8'h00, 1'b0);
			port_in <= pins;
			@(negedge clk);
			check("core_data_in", 16'(core_data_in), 16'(mixed_pins(pins)));
		end
		// Everything from address 2 upward comes from the external bus
		for (int i = 0; i < 4; i++)
		begin
			addr = {next_byte(), next_byte()};
			if (addr < 16'd2)
				addr = 16'h0002;
			bus_byte = next_byte();
			drive_cycle(addr, 8'h00, 1'b0);
			data_in <= bus_byte;
			@(negedge clk);
			check("core_data_in", 16'(core_data_in), 16'(bus_byte));
		end
	endtask

	// One gate phase with the given cycle, then the drive phase
	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data, input logic we,
		input logic [7:0] exp_data, input logic exp_rw);
		drive_cycle(addr, data, we);
		gate_in <= 1'b1;
		@(negedge clk);
		check("data_out", 16'(data_out), 16'h00ff);
		@(posedge clk);
		gate_in <= 1'b0;
		@(negedge clk);
		check("data_out", 16'(data_out), 16'(exp_data));
		check("rw", 16'(rw), 16'(exp_rw));
	endtask

	task automatic test_bus_write_data();
		logic [7:0] wbyte;
		wbyte = next_byte();
		bus_cycle(16'h1000, wbyte, 1'b1, wbyte, 1'b0);
		bus_cycle(16'h0000, next_byte(), 1'b1, 8'h00, 1'b0);
		bus_cycle(16'h0001, next_byte(), 1'b1, 8'h01, 1'b0);
		bus_cycle(16'h2000, next_byte(), 1'b0, 8'hff, 1'b1);
	endtask

	task automatic test_rdy_halt();
		for (int en = 0; en < 2; en++)
		begin
			drive_cycle(16'h3000, 8'h00, 1'b0);
			enable <= en[0];
			rdy    <= 1'b0;
			@(negedge clk);
			check("core_enable", 16'(core_enable), 16'h0000);
			drive_cycle(16'h3000, 8'h00, 1'b1);
			@(negedge clk);
			check("core_enable", 16'(core_enable), 16'(en[0]));
			drive_cycle(16'h3000, 8'h00, 1'b0);
			rdy <= 1'b1;
			@(negedge clk);
			check("core_enable", 16'(core_enable), 16'(en[0]));
		end
		@(posedge clk);
		enable <= 1'b0;
	endtask

	task automatic test_bus_release();
		logic [7:0] wbyte;
		wbyte = next_byte();
		bus_cycle(16'h4000, wbyte, 1'b1, wbyte, 1'b0);
		@(posedge clk);
		aec <= 1'b0;
		@(negedge clk);
		// Address lets go at once, rw waits for the delayed aec
		check("address", address, 16'hffff);
		check("rw", 16'(rw), 16'h0000);
		@(negedge clk);
		check("address", address, 16'hffff);
		check("rw", 16'(rw), 16'h0001);
		check("data_out", 16'(data_out), 16'h00ff);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		rng_state = 32'd26437;
		dir_model = 8'h00;
		data_model = 8'h00;
		reset <= 1'b1;
		enable <= 1'b0;
		irq_n <= 1'b1;
		core_bus.address <= 16'h0000;
		core_bus.data <= 8'h00;
		core_bus.we <= 1'b0;
		data_in <= 8'h00;
		gate_in <= 1'b0;
		rdy <= 1'b1;
		aec <= 1'b0;
		port_in <= 8'h00;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		test_reset_state();
		test_port_write_read();
		test_pin_mixing();
		test_bus_write_data();
		test_rdy_halt();
		test_bus_release();
		$display("Test passed");
		$finish;
	end

endmodule

// ==== mos8501_shell.f ====
common/mos8501_pkg.sv
src/access_control.sv
io_port/io_port.sv
bus/bus_interface.sv
src/mos8501_shell.sv
tb/mos8501_shell_properties.sv
tb/tb_mos8501_shell.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide by the pass line in the log
verilator --binary --timing --assert --top-module tb_mos8501_shell \
	-f mos8501_shell.f -o sim_mos8501_shell > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_mos8501_shell > sim.log 2>&1
cat sim.log
grep -qx "Test passed" sim.log && echo "Simulation OK" \
	|| { echo "Simulation reported a failure"; exit 1; }
